//--- src/isa_pkg.sv
// isa_pkg: data width, data word type, shift amount width and ALU opcode enum
`default_nettype none

package isa_pkg;

    // architectural data width
    localparam int unsigned xlen = 32;

    // shifts take only the low bits of operand b
    localparam int unsigned shamt_w = 5;

    typedef logic [xlen-1:0] data_t;

    // ALU opcodes, 4 bit encoding
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_sll  = 4'h5,
        alu_srl  = 4'h6,
        alu_sra  = 4'h7,
        // set less than, signed compare
        alu_slt  = 4'h8,
        // set less than, unsigned compare
        alu_sltu = 4'h9
    } alu_op_t;

    // encodings 4'ha to 4'hf are unused and yield zero in the ALU

endpackage

`default_nettype wire

//--- src/ooo_pkg.sv
// ooo_pkg: rob tag type, operand struct, unit issue and result packets, CDB packet
`default_nettype none

package ooo_pkg;

    // 32 entry reorder buffer
    localparam int unsigned rob_tag_w = 5;

    typedef logic [rob_tag_w-1:0] rob_tag_t;

    // one source operand as seen by a unit
    // ready set: value is valid
    // ready clear: tag names the producing ROB entry
    typedef struct packed {
        logic          ready;
        rob_tag_t      tag;
        isa_pkg::data_t value;
    } operand_t;

    // issue packet from the reservation station, one per unit slot
    typedef struct packed {
        logic             issue_valid;
        isa_pkg::alu_op_t op;
        rob_tag_t         rob_tag;
        operand_t         src_a;
        operand_t         src_b;
    } fu_in_packet_t;

    // registered unit output, held until the arbiter acks it
    typedef struct packed {
        logic           done;
        rob_tag_t       rob_tag;
        isa_pkg::data_t result;
    } fu_out_packet_t;

    // common data bus broadcast
    typedef struct packed {
        logic           valid;
        rob_tag_t       rob_tag;
        isa_pkg::data_t value;
    } cdb_packet_t;

endpackage

`default_nettype wire

//--- src/operand_bypass.sv
// operand_bypass: captures pending operands from the CDB when their tags match
`timescale 1ns/1ps
`default_nettype none

module operand_bypass #(
    parameter int unsigned num_fu = 4
) (
    input  ooo_pkg::fu_in_packet_t [num_fu-1:0] rs_packets,
    input  ooo_pkg::cdb_packet_t                cdb_packet,
    output ooo_pkg::fu_in_packet_t [num_fu-1:0] fu_packets
);

    import ooo_pkg::*;

    // a pending operand takes the bus value when the bus carries its tag
    function automatic operand_t resolve(
        input operand_t    src,
        input cdb_packet_t bus
    );
        operand_t res;
        res = src;
        if (!src.ready && bus.valid && (src.tag == bus.rob_tag)) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    // per slot forwarding, control fields pass through untouched
    always_comb begin
        for (int i = 0; i < num_fu; i++) begin
            fu_packets[i].issue_valid = rs_packets[i].issue_valid;
            fu_packets[i].op          = rs_packets[i].op;
            fu_packets[i].rob_tag     = rs_packets[i].rob_tag;
            fu_packets[i].src_a       = resolve(rs_packets[i].src_a, cdb_packet);
            fu_packets[i].src_b       = resolve(rs_packets[i].src_b, cdb_packet);
        end
    end

    // the bus comes from registered unit outputs only,
    // so this path never loops back combinationally

endmodule

`default_nettype wire

//--- src/alu_fu.sv
// alu_fu: single cycle ALU unit with registered result held until acked
`timescale 1ns/1ps
`default_nettype none

module alu_fu (
    input  logic                    clock,
    input  logic                    reset,
    input  ooo_pkg::fu_in_packet_t  fu_in_packet,
    input  logic                    ack,
    output ooo_pkg::fu_out_packet_t fu_out_packet,
    output logic                    busy
);

    import isa_pkg::*;
    import ooo_pkg::*;

    data_t              opa;
    data_t              opb;
    logic [shamt_w-1:0] shamt;
    data_t              alu_result;

    logic     done_q;
    rob_tag_t rob_tag_q;
    data_t    result_q;

    assign opa   = fu_in_packet.src_a.value;
    assign opb   = fu_in_packet.src_b.value;
    assign shamt = opb[shamt_w-1:0];

    // result datapath
    always_comb begin
        case (fu_in_packet.op)
            alu_add:  alu_result = opa + opb;
            alu_sub:  alu_result = opa - opb;
            alu_and:  alu_result = opa & opb;
            alu_or:   alu_result = opa | opb;
            alu_xor:  alu_result = opa ^ opb;
            alu_sll:  alu_result = opa << shamt;
            alu_srl:  alu_result = opa >> shamt;
            alu_sra:  alu_result = data_t'($signed(opa) >>> shamt);
            alu_slt: begin
                alu_result = data_t'($signed(opa) < $signed(opb));
            end
            alu_sltu: begin
                alu_result = data_t'(opa < opb);
            end
            default:  alu_result = '0;
        endcase
    end

    // done flag
    // issue wins over ack, so a new instruction can land
    // in the same edge the old result leaves on the bus
    always_ff @(posedge clock) begin
        if (reset) begin
            done_q <= 1'b0;
        end else if (fu_in_packet.issue_valid) begin
            done_q <= 1'b1;
        end else if (ack) begin
            done_q <= 1'b0;
        end
    end

    // payload, captured on issue and held under back-pressure
    always_ff @(posedge clock) begin
        if (fu_in_packet.issue_valid) begin
            rob_tag_q <= fu_in_packet.rob_tag;
            result_q  <= alu_result;
        end
    end

    assign fu_out_packet.done    = done_q;
    assign fu_out_packet.rob_tag = rob_tag_q;
    assign fu_out_packet.result  = result_q;

    // still waiting for the bus
    assign busy = done_q && !ack;

endmodule

`default_nettype wire

//--- src/cdb_arbiter.sv
// cdb_arbiter: round-robin grant of finished units onto the CDB, acks and done pulses
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter #(
    parameter int unsigned num_fu = 4
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  ooo_pkg::fu_out_packet_t [num_fu-1:0] fu_out_packets,
    output logic [num_fu-1:0]                    ack,
    output logic [num_fu-1:0]                    fu_done,
    output ooo_pkg::cdb_packet_t                 cdb_packet
);

    import ooo_pkg::*;

    localparam int unsigned ptr_w = (num_fu > 1) ? $clog2(num_fu) : 1;

    logic [ptr_w-1:0]  ptr_q;
    logic [ptr_w-1:0]  winner;
    logic              found;
    logic [num_fu-1:0] grant;

    // first done unit at or after the pointer, wrapping around
    always_comb begin
        int unsigned scan_idx;
        found  = 1'b0;
        winner = '0;
        for (int unsigned k = 0; k < num_fu; k++) begin
            scan_idx = (int'(ptr_q) + k) % num_fu;
            if (!found && fu_out_packets[scan_idx].done) begin
                found  = 1'b1;
                winner = ptr_w'(scan_idx);
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found) begin
            grant[winner] = 1'b1;
        end
    end

    assign ack     = grant;
    assign fu_done = grant;

    // bus carries the winner's registered tag and result
    assign cdb_packet.valid   = found;
    assign cdb_packet.rob_tag = fu_out_packets[winner].rob_tag;
    assign cdb_packet.value   = fu_out_packets[winner].result;

    // pointer moves to the unit just after the winner
    always_ff @(posedge clock) begin
        if (reset) begin
            ptr_q <= '0;
        end else if (found) begin
            if (winner == ptr_w'(num_fu - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= winner + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/ex_stage.sv
// ex_stage: execute stage top with operand bypass, ALU unit array and CDB arbiter
`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
    parameter int unsigned num_fu = 4
) (
    input  logic                                clock,
    input  logic                                reset,
    input  ooo_pkg::fu_in_packet_t [num_fu-1:0] rs_packets,
    output ooo_pkg::cdb_packet_t                cdb_packet,
    output logic [num_fu-1:0]                   fu_done,
    output logic [num_fu-1:0]                   busy
);

    import ooo_pkg::*;

    // resolved issue packets after CDB forwarding
    fu_in_packet_t [num_fu-1:0]  fu_packets;
    // registered unit results towards the arbiter
    fu_out_packet_t [num_fu-1:0] fu_out_packets;
    logic [num_fu-1:0]           ack;

    // forwarding uses the stage's own bus output
    operand_bypass #(
        .num_fu (num_fu)
    ) i_operand_bypass (
        .rs_packets (rs_packets),
        .cdb_packet (cdb_packet),
        .fu_packets (fu_packets)
    );

    // slot i feeds unit i
    for (genvar i = 0; i < num_fu; i++) begin : g_alu
        alu_fu i_alu_fu (
            .clock         (clock),
            .reset         (reset),
            .fu_in_packet  (fu_packets[i]),
            .ack           (ack[i]),
            .fu_out_packet (fu_out_packets[i]),
            .busy          (busy[i])
        );
    end

    cdb_arbiter #(
        .num_fu (num_fu)
    ) i_cdb_arbiter (
        .clock          (clock),
        .reset          (reset),
        .fu_out_packets (fu_out_packets),
        .ack            (ack),
        .fu_done        (fu_done),
        .cdb_packet     (cdb_packet)
    );

endmodule

`default_nettype wire

//--- tb/ex_stage_assertions.sv
// ex_stage_assertions: issue and CDB protocol properties, bound into ex_stage
`timescale 1ns/1ps
`default_nettype none

module ex_stage_assertions #(
    parameter int unsigned num_fu = 4
) (
    input logic                                clock,
    input logic                                reset,
    input ooo_pkg::fu_in_packet_t [num_fu-1:0] rs_packets,
    input ooo_pkg::cdb_packet_t                cdb_packet,
    input logic [num_fu-1:0]                   fu_done,
    input logic [num_fu-1:0]                   busy
);

    // number of failed properties so far
    int unsigned assert_failures = 0;

    // one bus winner per cycle
    a_one_grant: assert property (@(posedge clock) disable iff (reset) $onehot0(fu_done))
        else begin
            $error("more than one fu_done bit set");
            assert_failures++;
        end

    a_valid_grant: assert property (@(posedge clock) disable iff (reset)
        cdb_packet.valid == (|fu_done))
        else begin
            $error("cdb valid does not follow fu_done");
            assert_failures++;
        end

    for (genvar i = 0; i < num_fu; i++) begin : g_unit
        a_no_busy_issue: assert property (@(posedge clock) disable iff (reset)
            rs_packets[i].issue_valid |-> !busy[i])
            else begin
                $error("issue to busy unit %0d", i);
                assert_failures++;
            end

        // a waiting result stays put until its grant
        a_hold_busy: assert property (@(posedge clock) disable iff (reset)
            busy[i] |=> (busy[i] || fu_done[i]))
            else begin
                $error("unit %0d dropped busy without fu_done", i);
                assert_failures++;
            end
    end

endmodule

bind ex_stage ex_stage_assertions #(
    .num_fu (num_fu)
) i_ex_stage_assertions (
    .clock      (clock),
    .reset      (reset),
    .rs_packets (rs_packets),
    .cdb_packet (cdb_packet),
    .fu_done    (fu_done),
    .busy       (busy)
);

`default_nettype wire

//--- tb/ex_stage_tb.sv
// ex_stage_tb: table-driven testbench with cycle model, LFSR operands, watchdog and report
`timescale 1ns/1ps
`default_nettype none

module ex_stage_tb;

    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int num_fu      = 4;
    localparam int clk_half    = 4;
    localparam int reset_cycles = 16;
    localparam int n_entries   = 18;

    // one row of stimulus
    // order holds the expected winning unit per grant, one nibble each, first grant lowest
    typedef struct packed {
        logic [num_fu-1:0] mask;
        logic [1:0]        waves;
        alu_op_t           op;
        rob_tag_t          tag;
        logic              rnd;
        data_t             a;
        data_t             b;
        logic [1:0]        dep;
        logic [3:0]        n_grants;
        logic [31:0]       order;
    } entry_t;

    logic                       clock;
    logic                       reset;
    fu_in_packet_t [num_fu-1:0] rs_packets;
    cdb_packet_t                cdb_packet;
    logic [num_fu-1:0]          fu_done;
    logic [num_fu-1:0]          busy;

    entry_t      stim_table [n_entries];
    logic [31:0] lfsr_state;
    int          error_count;
    int          failed_tests;
    int          issued_count;
    int          granted_count;
    int          grant_log [8];
    int          log_count;
    int          assert_count;

    // reference model state, updated once per cycle
    logic [num_fu-1:0] m_done;
    rob_tag_t          m_tag [num_fu];
    data_t             m_val [num_fu];
    int                m_ptr;

    ex_stage #(
        .num_fu (num_fu)
    ) i_dut (
        .clock      (clock),
        .reset      (reset),
        .rs_packets (rs_packets),
        .cdb_packet (cdb_packet),
        .fu_done    (fu_done),
        .busy       (busy)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_half) clock = ~clock;
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic data_t random_word();
        data_t w;
        w = '0;
        for (int i = 0; i < xlen; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[xlen-2:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic data_t alu_model(input alu_op_t op, input data_t a, input data_t b);
        int unsigned sh;
        data_t       fill;
        data_t       sign;
        sh   = b[4:0];
        fill = a[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0;
        sign = data_t'(1) << (xlen - 1);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 1;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            alu_sra:  return (a >> sh) | fill;
            alu_slt:  return ((a ^ sign) < (b ^ sign)) ? data_t'(1) : '0;
            alu_sltu: return (a < b) ? data_t'(1) : '0;
            default:  return '0;
        endcase
    endfunction

    function automatic int first_set(input logic [num_fu-1:0] v);
        for (int i = 0; i < num_fu; i++) begin
            if (v[i] === 1'b1) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic fu_in_packet_t make_packet(input entry_t e, input rob_tag_t tag);
        fu_in_packet_t p;
        p             = '0;
        p.issue_valid = 1'b1;
        p.op          = e.op;
        p.rob_tag     = tag;
        p.src_a.ready = 1'b1;
        p.src_b.ready = 1'b1;
        p.src_a.value = e.rnd ? random_word() : e.a;
        p.src_b.value = e.rnd ? random_word() : e.b;
        return p;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("MISMATCH at %0t: %s expected %0h actual %0h", $time, name, exp, act);
        error_count++;
    endtask

    // mask, waves, op, tag, rnd, a, b, dep (1 match, 2 other tag), n_grants, order
    task automatic load_table();
        stim_table[0]  = '{4'b0001, 2'd1, alu_add,  5'd1,  1'b1, '0, '0, 2'd0, 4'd1, 32'h0};
        stim_table[1]  = '{4'b0001, 2'd1, alu_sub,  5'd2,  1'b1, '0, '0, 2'd0, 4'd1, 32'h0};
        stim_table[2]  = '{4'b0001, 2'd1, alu_and,  5'd3,  1'b1, '0, '0, 2'd0, 4'd1, 32'h0};
        stim_table[3]  = '{4'b0001, 2'd1, alu_or,   5'd4,  1'b1, '0, '0, 2'd0, 4'd1, 32'h0};
        stim_table[4]  = '{4'b0001, 2'd1, alu_xor,  5'd5,  1'b1, '0, '0, 2'd0, 4'd1, 32'h0};
        stim_table[5]  = '{4'b0001, 2'd1, alu_sll,  5'd6,  1'b1, '0, '0, 2'd0, 4'd1, 32'h0};
        stim_table[6]  = '{4'b0001, 2'd1, alu_srl,  5'd7,  1'b1, '0, '0, 2'd0, 4'd1, 32'h0};
        // shift amount 4, upper bits of b ignored
        stim_table[7]  = '{4'b0001, 2'd1, alu_sra,  5'd8,  1'b0, 32'hf000_0f00, 32'h24,
                           2'd0, 4'd1, 32'h0};
        stim_table[8]  = '{4'b0001, 2'd1, alu_slt,  5'd9,  1'b0, 32'hffff_fffe, 32'h1,
                           2'd0, 4'd1, 32'h0};
        stim_table[9]  = '{4'b0001, 2'd1, alu_sltu, 5'd10, 1'b0, 32'hffff_fffe, 32'h1,
                           2'd0, 4'd1, 32'h0};
        stim_table[10] = '{4'b0010, 2'd1, alu_add,  5'd12, 1'b1, '0, '0, 2'd1, 4'd2, 32'h01};
        stim_table[11] = '{4'b0010, 2'd1, alu_xor,  5'd14, 1'b1, '0, '0, 2'd2, 4'd2, 32'h01};
        stim_table[12] = '{4'b1111, 2'd1, alu_sub,  5'd16, 1'b1, '0, '0, 2'd0, 4'd4, 32'h0321};
        stim_table[13] = '{4'b0100, 2'd1, alu_or,   5'd20, 1'b1, '0, '0, 2'd0, 4'd1, 32'h2};
        stim_table[14] = '{4'b1111, 2'd1, alu_sra,  5'd21, 1'b1, '0, '0, 2'd0, 4'd4, 32'h2103};
        stim_table[15] = '{4'b1010, 2'd1, alu_slt,  5'd25, 1'b1, '0, '0, 2'd0, 4'd2, 32'h13};
        stim_table[16] = '{4'b1111, 2'd1, alu_sltu, 5'd27, 1'b1, '0, '0, 2'd0, 4'd4, 32'h1032};
        // back to back on unit 0, each issue lands in the acked cycle
        stim_table[17] = '{4'b0001, 2'd3, alu_add,  5'd3,  1'b1, '0, '0, 2'd0, 4'd3, 32'h000};
    endtask

    // cycle model, checks the outputs then advances past the next edge
    always @(negedge clock) begin : model_check
        int unsigned       idx;
        logic              hit;
        int                win;
        logic [num_fu-1:0] grant;
        rob_tag_t          bus_tag;
        data_t             bus_val;
        data_t             a;
        data_t             b;
        if (reset) begin
            m_done = '0;
            m_ptr  = 0;
        end else begin
            hit = 1'b0;
            win = 0;
            for (int k = 0; k < num_fu; k++) begin
                idx = (m_ptr + k) % num_fu;
                if (!hit && m_done[idx]) begin
                    hit = 1'b1;
                    win = idx;
                end
            end
            grant   = '0;
            grant[win] = hit;
            bus_tag = m_tag[win];
            bus_val = m_val[win];
            if (fu_done !== grant) begin
                report_mismatch("fu_done", grant, fu_done);
            end
            if (busy !== (m_done & ~grant)) begin
                report_mismatch("busy", m_done & ~grant, busy);
            end
            if (cdb_packet.valid !== hit) begin
                report_mismatch("cdb_packet.valid", hit, cdb_packet.valid);
            end
            if (hit) begin
                if (cdb_packet.rob_tag !== bus_tag) begin
                    report_mismatch("cdb_packet.rob_tag", bus_tag, cdb_packet.rob_tag);
                end
                if (cdb_packet.value !== bus_val) begin
                    report_mismatch("cdb_packet.value", bus_val, cdb_packet.value);
                end
                if (log_count < 8) begin
                    grant_log[log_count] = first_set(fu_done);
                end
                log_count++;
                granted_count++;
                m_ptr = (win + 1) % num_fu;
            end
            for (int u = 0; u < num_fu; u++) begin
                if (rs_packets[u].issue_valid && m_done[u] && !grant[u]) begin
                    $display("ERROR at %0t: unit %0d issued while busy", $time, u);
                    error_count++;
                end
                if (rs_packets[u].issue_valid) begin
                    a = rs_packets[u].src_a.value;
                    b = rs_packets[u].src_b.value;
                    if (!rs_packets[u].src_a.ready && hit
                            && rs_packets[u].src_a.tag == bus_tag) begin
                        a = bus_val;
                    end
                    if (!rs_packets[u].src_b.ready && hit
                            && rs_packets[u].src_b.tag == bus_tag) begin
                        b = bus_val;
                    end
                    m_done[u] = 1'b1;
                    m_tag[u]  = rs_packets[u].rob_tag;
                    m_val[u]  = alu_model(rs_packets[u].op, a, b);
                end else if (grant[u]) begin
                    m_done[u] = 1'b0;
                end
            end
        end
    end

    task automatic check_reset_state();
        int err0;
        err0 = error_count;
        repeat (3) begin
            @(negedge clock);
            if (cdb_packet.valid !== 1'b0) begin
                report_mismatch("cdb_packet.valid", 0, cdb_packet.valid);
            end
            if (fu_done !== '0) begin
                report_mismatch("fu_done", 0, fu_done);
            end
            if (busy !== '0) begin
                report_mismatch("busy", 0, busy);
            end
        end
        if (error_count != err0) begin
            failed_tests++;
        end
        $display("test reset state: %s", (error_count == err0) ? "ok" : "failed");
    endtask

    task automatic run_entry(input int n);
        entry_t                     e;
        fu_in_packet_t [num_fu-1:0] pk;
        rob_tag_t                   tag;
        int                         guard;
        int                         err0;
        e         = stim_table[n];
        err0      = error_count;
        log_count = 0;
        tag       = e.tag;
        for (int w = 0; w < e.waves; w++) begin
            pk = '0;
            for (int s = 0; s < num_fu; s++) begin
                if (e.mask[s]) begin
                    pk[s] = make_packet(e, tag);
                    tag++;
                    issued_count++;
                end
            end
            @(posedge clock);
            rs_packets <= pk;
        end
        // dependent on slot 0, issued while the producer sits on the bus
        if (e.dep != 2'd0) begin
            pk             = '0;
            pk[0]          = make_packet(e, tag);
            pk[0].src_a.ready = 1'b0;
            pk[0].src_a.tag   = (e.dep == 2'd1) ? e.tag : (e.tag ^ 5'h10);
            issued_count++;
            @(posedge clock);
            rs_packets <= pk;
        end
        @(posedge clock);
        rs_packets <= '0;
        guard = 0;
        while (granted_count < issued_count && guard < num_fu + 4) begin
            @(posedge clock);
            guard++;
        end
        if (granted_count < issued_count) begin
            $display("ERROR at %0t: results missing from the bus in test %0d", $time, n);
            error_count++;
        end
        if (log_count != e.n_grants) begin
            report_mismatch("grant count", e.n_grants, log_count);
        end
        for (int k = 0; k < log_count && k < e.n_grants; k++) begin
            if (grant_log[k] != int'(e.order[4*k +: 4])) begin
                report_mismatch("grant order", e.order[4*k +: 4], grant_log[k]);
            end
        end
        if (error_count != err0) begin
            failed_tests++;
        end
        $display("test %0d op %s mask %b dep %0d: %s", n, e.op.name(), e.mask, e.dep,
                 (error_count == err0) ? "ok" : "failed");
    endtask

    initial begin
        rs_packets    = '0;
        reset         = 1'b1;
        lfsr_state    = 32'h5b4c;
        error_count   = 0;
        failed_tests  = 0;
        issued_count  = 0;
        granted_count = 0;
        log_count     = 0;
        assert_count  = 0;
        load_table();
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        check_reset_state();
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        @(posedge clock);
        assert_count = int'(i_dut.i_ex_stage_assertions.assert_failures);
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 n_entries + 1, failed_tests, error_count, assert_count);
        if (error_count == 0 && assert_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog, sized from the table length
    initial begin
        #((n_entries * (num_fu + 4) + reset_cycles) * 2 * clk_half);
        $display("watchdog expired at %0t before all tests finished", $time);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
src/isa_pkg.sv
src/ooo_pkg.sv
src/operand_bypass.sv
src/alu_fu.sv
src/cdb_arbiter.sv
src/ex_stage.sv
tb/ex_stage_assertions.sv
tb/ex_stage_tb.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - src/isa_pkg.sv
      - src/ooo_pkg.sv
      - src/operand_bypass.sv
      - src/alu_fu.sv
      - src/cdb_arbiter.sv
      - src/ex_stage.sv
  - target: test
    files:
      - tb/ex_stage_assertions.sv
      - tb/ex_stage_tb.sv
